// ==== src/mex_entry_pkg.sv ====
package mex_entry_pkg;

    // operand value and producer tag widths
    localparam int value_w = 16;
    localparam int tag_w = 4;
    localparam int opcode_w = 4;

    // producer or destination tag
    typedef logic [tag_w-1:0] tag_t;

    // pending view of an operand slot
    // tag sits in the low bits, upper bits stay zero
    typedef struct packed {
        logic [value_w-tag_w-1:0] zero;
        tag_t                     tag;
    } pending_slot_t;

    // one operand word, read as value or as pending tag
    // the entry's wake bit selects the reading
    typedef union packed {
        logic [value_w-1:0] value;
        pending_slot_t      pending;
    } operand_slot_u;

    // modifiable part, rewritten in place on wakeup
    typedef struct packed {
        operand_slot_u slot_a;
        operand_slot_u slot_b;
        logic          wake_a;
        logic          wake_b;
    } m_part_t;

    // fixed part, untouched after the write
    typedef struct packed {
        logic [opcode_w-1:0] opcode;
        tag_t                dest;
    } n_part_t;

    // full queue entry, modifiable part on top
    typedef struct packed {
        m_part_t m;
        n_part_t n;
    } entry_t;

endpackage

// ==== src/mex_csr_pkg.sv ====
package mex_csr_pkg;

    // register bus widths
    localparam int csr_addr_w = 2;
    localparam int csr_data_w = 16;

    typedef logic [csr_addr_w-1:0] csr_addr_t;

    // register map
    localparam csr_addr_t addr_ctrl = 2'd0;
    // occupancy, read only
    localparam csr_addr_t addr_status = 2'd1;
    // wake event count, any write clears
    localparam csr_addr_t addr_wake_cnt = 2'd2;

    // control register bits
    localparam int ctrl_wake_en_bit = 0;
    // write 1, clears itself next cycle
    localparam int ctrl_flush_bit = 1;

    // wake enable out of reset
    localparam logic ctrl_wake_en_rst = 1'b1;

endpackage

// ==== src/mex_queued_latches.sv ====
`timescale 1ns/100ps

module mex_queued_latches #(
    parameter int DEPTH = 8
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    // MEM side
    input  logic                                   in_valid,
    input  mex_entry_pkg::entry_t                  in_entry,
    output logic                                   in_ready,
    // EX side
    output logic                                   out_valid,
    output mex_entry_pkg::entry_t                  out_entry,
    input  logic                                   out_ready,
    // in-place update of the modifiable parts
    input  logic [DEPTH-1:0]                       modify_vector,
    input  mex_entry_pkg::m_part_t [DEPTH-1:0]     new_m_vector,
    output mex_entry_pkg::m_part_t [DEPTH-1:0]     old_m_vector,
    // control and status
    input  logic                                   flush,
    output logic [$clog2(DEPTH+1)-1:0]             occupancy
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // entry storage
    mex_entry_pkg::entry_t slots [DEPTH];

    // per-slot occupied flags
    logic [DEPTH-1:0] slot_vld;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic                  push;
    logic                  pop;
    mex_entry_pkg::entry_t head;

    // pointer advance with wrap for any depth
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // handshakes
    assign in_ready = (count != CNT_W'(DEPTH));
    assign push     = in_valid && in_ready;
    assign pop      = out_valid && out_ready;

    // head only leaves once both operands are awake
    assign head      = slots[rd_ptr];
    assign out_entry = head;
    assign out_valid = (count != '0) && head.m.wake_a && head.m.wake_b;
    assign occupancy = count;

    // pointers, count and occupied flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            slot_vld <= '0;
        end else if (flush) begin
            // drop everything, slot contents stay as they are
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            slot_vld <= '0;
        end else begin
            if (push) begin
                wr_ptr           <= ptr_next(wr_ptr);
                slot_vld[wr_ptr] <= 1'b1;
            end
            // push and pop never hit the same slot
            if (pop) begin
                rd_ptr           <= ptr_next(rd_ptr);
                slot_vld[rd_ptr] <= 1'b0;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage update
    // a new write takes the whole entry, otherwise only the m part may change
    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (push && !flush && (wr_ptr == PTR_W'(i))) begin
                slots[i] <= in_entry;
            end else if (modify_vector[i]) begin
                slots[i].m <= new_m_vector[i];
            end
        end
    end

    // modifiable parts out to the matcher
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            old_m_vector[i] = slots[i].m;
            // empty slot looks fully awake so stale tags never match
            if (!slot_vld[i]) begin
                old_m_vector[i].wake_a = 1'b1;
                old_m_vector[i].wake_b = 1'b1;
            end
        end
    end

endmodule

// ==== src/mex_wakeup_match.sv ====
`timescale 1ns/100ps

module mex_wakeup_match #(
    parameter int DEPTH = 8
) (
    input  logic                                   wake_en,
    // result broadcast
    input  logic                                   res_valid,
    input  mex_entry_pkg::tag_t                    res_tag,
    input  logic [mex_entry_pkg::value_w-1:0]      res_value,
    // stored entries
    input  mex_entry_pkg::m_part_t [DEPTH-1:0]     old_m_vector,
    output mex_entry_pkg::m_part_t [DEPTH-1:0]     new_m_vector,
    output logic [DEPTH-1:0]                       modify_vector,
    // entry on its way in
    input  mex_entry_pkg::entry_t                  in_entry,
    output mex_entry_pkg::entry_t                  in_entry_woken,
    output logic                                   wake_hit
);

    // hit per operand, bit 1 is slot a, bit 0 is slot b
    function automatic logic [1:0] match_bits(
        input mex_entry_pkg::m_part_t m,
        input logic                   fire,
        input mex_entry_pkg::tag_t    tag
    );
        logic [1:0] hits;
        hits[1] = fire && !m.wake_a && (m.slot_a.pending.tag == tag);
        hits[0] = fire && !m.wake_b && (m.slot_b.pending.tag == tag);
        return hits;
    endfunction

    // woken operand takes the value and flips to the value reading
    function automatic mex_entry_pkg::m_part_t apply_wake(
        input mex_entry_pkg::m_part_t              m,
        input logic [1:0]                          hits,
        input logic [mex_entry_pkg::value_w-1:0]   value
    );
        mex_entry_pkg::m_part_t r;
        r = m;
        if (hits[1]) begin
            r.slot_a.value = value;
            r.wake_a       = 1'b1;
        end
        if (hits[0]) begin
            r.slot_b.value = value;
            r.wake_b       = 1'b1;
        end
        return r;
    endfunction

    logic       fire;
    logic [1:0] slot_hits [DEPTH];
    logic [1:0] in_hits;

    // broadcast only counts with wakeup enabled
    assign fire = res_valid && wake_en;

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            slot_hits[i]     = match_bits(old_m_vector[i], fire, res_tag);
            modify_vector[i] = |slot_hits[i];
            new_m_vector[i]  = apply_wake(old_m_vector[i], slot_hits[i], res_value);
        end
        // same rule for the entry being written this cycle
        in_hits          = match_bits(in_entry.m, fire, res_tag);
        in_entry_woken   = in_entry;
        in_entry_woken.m = apply_wake(in_entry.m, in_hits, res_value);
        wake_hit         = (|modify_vector) || (|in_hits);
    end

endmodule

// ==== src/mex_csr.sv ====
`timescale 1ns/100ps

module mex_csr #(
    parameter int DEPTH = 8
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    // register port
    input  logic                                     csr_we,
    input  mex_csr_pkg::csr_addr_t                   csr_addr,
    input  logic [mex_csr_pkg::csr_data_w-1:0]       csr_wdata,
    output logic [mex_csr_pkg::csr_data_w-1:0]       csr_rdata,
    // status in
    input  logic [$clog2(DEPTH+1)-1:0]               occupancy,
    input  logic                                     wake_hit,
    // control out
    output logic                                     wake_en,
    output logic                                     flush
);

    localparam int OCC_W = $clog2(DEPTH + 1);

    logic [mex_csr_pkg::csr_data_w-1:0] wake_cnt;
    logic                               ctrl_wr;
    logic                               cnt_wr;

    assign ctrl_wr = csr_we && (csr_addr == mex_csr_pkg::addr_ctrl);
    assign cnt_wr  = csr_we && (csr_addr == mex_csr_pkg::addr_wake_cnt);

    // wake enable and one-cycle flush pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wake_en <= mex_csr_pkg::ctrl_wake_en_rst;
            flush   <= 1'b0;
        end else begin
            flush <= 1'b0;
            if (ctrl_wr) begin
                wake_en <= csr_wdata[mex_csr_pkg::ctrl_wake_en_bit];
                flush   <= csr_wdata[mex_csr_pkg::ctrl_flush_bit];
            end
        end
    end

    // wake event counter, sticks at all ones
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wake_cnt <= '0;
        end else if (cnt_wr) begin
            // a write clears, whatever the data
            wake_cnt <= '0;
        end else if (wake_hit && (wake_cnt != '1)) begin
            wake_cnt <= wake_cnt + 1'b1;
        end
    end

    // readback mux
    always_comb begin
        csr_rdata = '0;
        case (csr_addr)
            mex_csr_pkg::addr_ctrl: begin
                csr_rdata[mex_csr_pkg::ctrl_wake_en_bit] = wake_en;
                csr_rdata[mex_csr_pkg::ctrl_flush_bit]   = flush;
            end
            mex_csr_pkg::addr_status:   csr_rdata[OCC_W-1:0] = occupancy;
            mex_csr_pkg::addr_wake_cnt: csr_rdata = wake_cnt;
            default:                    csr_rdata = '0;
        endcase
    end

endmodule

// ==== src/mex_stage_top.sv ====
`timescale 1ns/100ps

module mex_stage_top #(
    parameter int DEPTH = 8
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    // from MEM
    input  logic                                 in_valid,
    input  mex_entry_pkg::entry_t                in_entry,
    output logic                                 in_ready,
    // to EX
    output logic                                 out_valid,
    output mex_entry_pkg::entry_t                out_entry,
    input  logic                                 out_ready,
    // result broadcast
    input  logic                                 res_valid,
    input  mex_entry_pkg::tag_t                  res_tag,
    input  logic [mex_entry_pkg::value_w-1:0]    res_value,
    // register port
    input  logic                                 csr_we,
    input  mex_csr_pkg::csr_addr_t               csr_addr,
    input  logic [mex_csr_pkg::csr_data_w-1:0]   csr_wdata,
    output logic [mex_csr_pkg::csr_data_w-1:0]   csr_rdata
);

    mex_entry_pkg::m_part_t [DEPTH-1:0] old_m_vector;
    mex_entry_pkg::m_part_t [DEPTH-1:0] new_m_vector;
    logic [DEPTH-1:0]                   modify_vector;
    mex_entry_pkg::entry_t              match_in;
    mex_entry_pkg::entry_t              in_entry_woken;
    logic                               wake_hit;
    logic                               wake_en;
    logic                               flush;
    logic [$clog2(DEPTH+1)-1:0]         occupancy;

    // incoming entry only joins the match when it is taken this cycle
    always_comb begin
        match_in = in_entry;
        if (!(in_valid && in_ready)) begin
            match_in.m.wake_a = 1'b1;
            match_in.m.wake_b = 1'b1;
        end
    end

    mex_queued_latches #(.DEPTH(DEPTH)) q0 (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_entry(in_entry_woken), .in_ready(in_ready),
        .out_valid(out_valid), .out_entry(out_entry), .out_ready(out_ready),
        .modify_vector(modify_vector), .new_m_vector(new_m_vector),
        .old_m_vector(old_m_vector), .flush(flush), .occupancy(occupancy)
    );

    mex_wakeup_match #(.DEPTH(DEPTH)) wm0 (
        .wake_en(wake_en), .res_valid(res_valid), .res_tag(res_tag),
        .res_value(res_value), .old_m_vector(old_m_vector),
        .new_m_vector(new_m_vector), .modify_vector(modify_vector),
        .in_entry(match_in), .in_entry_woken(in_entry_woken), .wake_hit(wake_hit)
    );

    mex_csr #(.DEPTH(DEPTH)) csr0 (
        .clk(clk), .rst_n(rst_n),
        .csr_we(csr_we), .csr_addr(csr_addr), .csr_wdata(csr_wdata),
        .csr_rdata(csr_rdata), .occupancy(occupancy), .wake_hit(wake_hit),
        .wake_en(wake_en), .flush(flush)
    );

endmodule

// ==== verif/mex_tb.sv ====
`timescale 1ns/100ps

module mex_tb;

    logic                         clk;
    logic                         rst_n;
    logic                         in_valid;
    mex_entry_pkg::entry_t        in_entry;
    logic                         in_ready;
    logic                         out_valid;
    mex_entry_pkg::entry_t        out_entry;
    logic                         out_ready;
    logic                         res_valid;
    mex_entry_pkg::tag_t          res_tag;
    logic [15:0]                  res_value;
    logic                         csr_we;
    mex_csr_pkg::csr_addr_t       csr_addr;
    logic [15:0]                  csr_wdata;
    logic [15:0]                  csr_rdata;

    // reference queue and what the last cycle looked like
    mex_entry_pkg::entry_t model_q[$];
    logic        model_wake_en;
    int          hit_cycles;
    int          pop_count;
    int          value_errors;
    int          other_errors;
    string       cur_test;
    logic        last_accepted;
    logic        last_in_ready;
    logic        last_out_valid;
    logic [15:0] last_rdata;
    logic [15:0] rd;
    int unsigned seed;

    mex_stage_top #(.DEPTH(8)) dut0 (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_entry(in_entry), .in_ready(in_ready),
        .out_valid(out_valid), .out_entry(out_entry), .out_ready(out_ready),
        .res_valid(res_valid), .res_tag(res_tag), .res_value(res_value),
        .csr_we(csr_we), .csr_addr(csr_addr), .csr_wdata(csr_wdata),
        .csr_rdata(csr_rdata)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        value_errors++;
    endtask

    task automatic timeout_abort(input string what);
        $display("%s timed out waiting for %s", cur_test, what);
        $display("value errors %0d, other errors %0d, timeouts 1", value_errors, other_errors);
        $display("Simulation FAILED");
        $finish;
    endtask

    // random entry, pending operands carry their tag in the low bits
    function automatic mex_entry_pkg::entry_t make_entry(
        input logic pend_a, input mex_entry_pkg::tag_t tag_a,
        input logic pend_b, input mex_entry_pkg::tag_t tag_b
    );
        mex_entry_pkg::entry_t e;
        e.n.opcode       = 4'($urandom);
        e.n.dest         = 4'($urandom);
        e.m.slot_a.value = 16'($urandom);
        e.m.slot_b.value = 16'($urandom);
        e.m.wake_a       = !pend_a;
        e.m.wake_b       = !pend_b;
        if (pend_a) begin
            e.m.slot_a.pending.zero = '0;
            e.m.slot_a.pending.tag  = tag_a;
        end
        if (pend_b) begin
            e.m.slot_b.pending.zero = '0;
            e.m.slot_b.pending.tag  = tag_b;
        end
        return e;
    endfunction

    // one clock of stimulus, sampled at the falling edge
    task automatic run_cycle(input logic iv, input mex_entry_pkg::entry_t ie,
                             input logic ordy, input logic rv,
                             input mex_entry_pkg::tag_t rt, input logic [15:0] rval);
        mex_entry_pkg::entry_t e;
        logic exp_ov;
        logic any_hit;
        in_valid  = iv;
        in_entry  = ie;
        out_ready = ordy;
        res_valid = rv;
        res_tag   = rt;
        res_value = rval;
        @(negedge clk);
        last_in_ready  = in_ready;
        last_out_valid = out_valid;
        last_rdata     = csr_rdata;
        last_accepted  = in_valid && in_ready;
        // handshake flags predicted from the model
        exp_ov = (model_q.size() != 0) && model_q[0].m.wake_a && model_q[0].m.wake_b;
        if (out_valid !== exp_ov) report_mismatch({cur_test, " out_valid"}, exp_ov, out_valid);
        if (in_ready !== (model_q.size() != 8)) begin
            report_mismatch({cur_test, " in_ready"}, model_q.size() != 8, in_ready);
        end
        // issued entry against the model head
        if (out_valid && out_ready) begin
            pop_count++;
            if (model_q.size() == 0) begin
                other_errors++;
                $display("%s: DUT issued an entry that was never sent", cur_test);
            end else begin
                e = model_q.pop_front();
                if (out_entry !== e) report_mismatch(cur_test, e, out_entry);
            end
        end
        if (last_accepted) model_q.push_back(ie);
        // broadcast wakes matching pending operands, the new entry included
        if (rv && model_wake_en) begin
            any_hit = 1'b0;
            for (int i = 0; i < model_q.size(); i++) begin
                e = model_q[i];
                if (!e.m.wake_a && (e.m.slot_a.value[3:0] == rt)) begin
                    e.m.slot_a.value = rval;
                    e.m.wake_a       = 1'b1;
                    any_hit          = 1'b1;
                end
                if (!e.m.wake_b && (e.m.slot_b.value[3:0] == rt)) begin
                    e.m.slot_b.value = rval;
                    e.m.wake_b       = 1'b1;
                    any_hit          = 1'b1;
                end
                model_q[i] = e;
            end
            if (any_hit) hit_cycles++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycle(input logic ordy);
        run_cycle(1'b0, '0, ordy, 1'b0, '0, '0);
    endtask

    task automatic csr_write(input mex_csr_pkg::csr_addr_t addr, input logic [15:0] data,
                             input logic ordy);
        csr_we    = 1'b1;
        csr_addr  = addr;
        csr_wdata = data;
        idle_cycle(ordy);
        csr_we = 1'b0;
        if (addr == mex_csr_pkg::addr_ctrl) model_wake_en = data[mex_csr_pkg::ctrl_wake_en_bit];
        if (addr == mex_csr_pkg::addr_wake_cnt) hit_cycles = 0;
    endtask

    task automatic csr_read(input mex_csr_pkg::csr_addr_t addr, output logic [15:0] data);
        csr_addr = addr;
        idle_cycle(1'b0);
        data = last_rdata;
    endtask

    task automatic send_entry(input mex_entry_pkg::entry_t e, input logic ordy);
        int n;
        n = 0;
        run_cycle(1'b1, e, ordy, 1'b0, '0, '0);
        while (!last_accepted) begin
            n++;
            if (n > 40) timeout_abort("in_ready while sending an entry");
            run_cycle(1'b1, e, ordy, 1'b0, '0, '0);
        end
    endtask

    task automatic drain_queue();
        int n;
        n = 0;
        while (model_q.size() != 0) begin
            n++;
            if (n > 60) timeout_abort("the queue to drain");
            idle_cycle(1'b1);
        end
    endtask

    task automatic wait_for_pops(input int target);
        int n;
        n = 0;
        while (pop_count < target) begin
            n++;
            if (n > 40) timeout_abort("entries to issue");
            idle_cycle(1'b1);
        end
    endtask

    task automatic test_ready_flow();
        int start;
        cur_test = "test_ready_flow";
        start = pop_count;
        for (int k = 0; k < 12; k++) begin
            send_entry(make_entry(1'b0, '0, 1'b0, '0), 1'b1);
        end
        drain_queue();
        if (pop_count - start != 12) report_mismatch(cur_test, 12, pop_count - start);
        csr_read(mex_csr_pkg::addr_status, rd);
        if (rd !== 16'd0) report_mismatch(cur_test, 0, rd);
    endtask

    task automatic test_backpressure();
        int n_acc;
        cur_test = "test_backpressure";
        n_acc = 0;
        run_cycle(1'b1, make_entry(1'b0, '0, 1'b0, '0), 1'b0, 1'b0, '0, '0);
        while (last_accepted) begin
            n_acc++;
            if (n_acc > 20) timeout_abort("in_ready to drop");
            run_cycle(1'b1, make_entry(1'b0, '0, 1'b0, '0), 1'b0, 1'b0, '0, '0);
        end
        if (n_acc != 8) report_mismatch(cur_test, 8, n_acc);
        csr_read(mex_csr_pkg::addr_status, rd);
        if (rd !== 16'd8) report_mismatch(cur_test, 8, rd);
        drain_queue();
        csr_read(mex_csr_pkg::addr_status, rd);
        if (rd !== 16'd0) report_mismatch(cur_test, 0, rd);
    endtask

    task automatic test_wakeup();
        int start;
        cur_test = "test_wakeup";
        csr_write(mex_csr_pkg::addr_wake_cnt, 16'h0, 1'b0);
        start = pop_count;
        // head waits on 5, third entry on 3 and 5
        send_entry(make_entry(1'b1, 4'd5, 1'b0, '0), 1'b1);
        send_entry(make_entry(1'b0, '0, 1'b0, '0), 1'b1);
        send_entry(make_entry(1'b1, 4'd3, 1'b1, 4'd5), 1'b1);
        idle_cycle(1'b1);
        if (last_out_valid !== 1'b0) report_mismatch(cur_test, 0, last_out_valid);
        // write and broadcast of tag 5 in the same cycle
        run_cycle(1'b1, make_entry(1'b1, 4'd5, 1'b1, 4'd3), 1'b1, 1'b1, 4'd5, 16'($urandom));
        if (last_accepted !== 1'b1) report_mismatch(cur_test, 1, last_accepted);
        wait_for_pops(start + 2);
        // third entry still waits on tag 3 and blocks the fourth
        for (int k = 0; k < 3; k++) begin
            idle_cycle(1'b1);
            if (last_out_valid !== 1'b0) report_mismatch(cur_test, 0, last_out_valid);
        end
        // matching entry on the bus but not written, no wake event
        run_cycle(1'b0, make_entry(1'b1, 4'd7, 1'b0, '0), 1'b1, 1'b1, 4'd7, 16'($urandom));
        run_cycle(1'b0, '0, 1'b1, 1'b1, 4'd3, 16'($urandom));
        drain_queue();
        if (pop_count - start != 4) report_mismatch(cur_test, 4, pop_count - start);
        csr_read(mex_csr_pkg::addr_wake_cnt, rd);
        if (rd !== 16'(hit_cycles)) report_mismatch(cur_test, hit_cycles, rd);
    endtask

    task automatic test_wake_disable();
        cur_test = "test_wake_disable";
        csr_write(mex_csr_pkg::addr_wake_cnt, 16'h0, 1'b0);
        csr_write(mex_csr_pkg::addr_ctrl, 16'h0, 1'b0);
        send_entry(make_entry(1'b1, 4'd6, 1'b0, '0), 1'b1);
        send_entry(make_entry(1'b0, '0, 1'b1, 4'd6), 1'b1);
        run_cycle(1'b0, '0, 1'b1, 1'b1, 4'd6, 16'($urandom));
        for (int k = 0; k < 3; k++) begin
            idle_cycle(1'b1);
            if (last_out_valid !== 1'b0) report_mismatch(cur_test, 0, last_out_valid);
        end
        csr_read(mex_csr_pkg::addr_wake_cnt, rd);
        if (rd !== 16'(hit_cycles)) report_mismatch(cur_test, hit_cycles, rd);
        // enabled again, same tag now wakes both
        csr_write(mex_csr_pkg::addr_ctrl, 16'h1, 1'b0);
        run_cycle(1'b0, '0, 1'b1, 1'b1, 4'd6, 16'($urandom));
        drain_queue();
        csr_read(mex_csr_pkg::addr_wake_cnt, rd);
        if (rd !== 16'(hit_cycles)) report_mismatch(cur_test, hit_cycles, rd);
    endtask

    task automatic test_flush();
        cur_test = "test_flush";
        // entries left waiting on tag 9
        for (int k = 0; k < 5; k++) begin
            send_entry(make_entry(1'b1, 4'd9, 1'b0, '0), 1'b0);
        end
        // flush bit with wake enable kept on
        csr_write(mex_csr_pkg::addr_ctrl, 16'h3, 1'b0);
        idle_cycle(1'b0);
        model_q.delete();
        idle_cycle(1'b0);
        if (last_out_valid !== 1'b0) report_mismatch(cur_test, 0, last_out_valid);
        if (last_in_ready !== 1'b1) report_mismatch(cur_test, 1, last_in_ready);
        // flushed slots still hold tag 9 and must not wake
        run_cycle(1'b0, '0, 1'b0, 1'b1, 4'd9, 16'($urandom));
        csr_read(mex_csr_pkg::addr_wake_cnt, rd);
        if (rd !== 16'(hit_cycles)) report_mismatch(cur_test, hit_cycles, rd);
        csr_read(mex_csr_pkg::addr_status, rd);
        if (rd !== 16'd0) report_mismatch(cur_test, 0, rd);
        send_entry(make_entry(1'b0, '0, 1'b0, '0), 1'b1);
        drain_queue();
    endtask

    initial begin
        seed          = $urandom(32'h8e81);
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_entry      = '0;
        out_ready     = 1'b0;
        res_valid     = 1'b0;
        res_tag       = '0;
        res_value     = '0;
        csr_we        = 1'b0;
        csr_addr      = '0;
        csr_wdata     = '0;
        model_wake_en = 1'b1;
        hit_cycles    = 0;
        pop_count     = 0;
        value_errors  = 0;
        other_errors  = 0;
        cur_test      = "reset";
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // state right after reset
        idle_cycle(1'b0);
        if (last_in_ready !== 1'b1) report_mismatch(cur_test, 1, last_in_ready);
        if (last_out_valid !== 1'b0) report_mismatch(cur_test, 0, last_out_valid);
        csr_read(mex_csr_pkg::addr_ctrl, rd);
        if (rd !== 16'h1) report_mismatch(cur_test, 1, rd);
        csr_read(mex_csr_pkg::addr_status, rd);
        if (rd !== 16'h0) report_mismatch(cur_test, 0, rd);
        csr_read(mex_csr_pkg::addr_wake_cnt, rd);
        if (rd !== 16'h0) report_mismatch(cur_test, 0, rd);
        test_ready_flow();
        test_backpressure();
        test_wakeup();
        test_wake_disable();
        test_flush();
        $display("value errors %0d, other errors %0d, timeouts 0", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
src/mex_entry_pkg.sv
src/mex_csr_pkg.sv
src/mex_queued_latches.sv
src/mex_wakeup_match.sv
src/mex_csr.sv
src/mex_stage_top.sv
verif/mex_tb.sv

// ==== Bender.yml ====
package:
  name: mex_stage

sources:
  - src/mex_entry_pkg.sv
  - src/mex_csr_pkg.sv
  - src/mex_queued_latches.sv
  - src/mex_wakeup_match.sv
  - src/mex_csr.sv
  - src/mex_stage_top.sv
  - target: test
    files:
      - verif/mex_tb.sv
